// File: design/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////////////////////////
	// widths of the fetch path
	//////////////////////////////////////////////////

	parameter int ADDR_W = 64;	// byte address
	parameter int LINE_W = 64;	// one memory line, two instructions
	parameter int INST_W = 32;	// one instruction
	parameter int COUNT_W = 2;	// slot count, 0 to 2

	// byte offset bits inside a line
	parameter int LINE_OFFSET = 3;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [ADDR_W-1:0] addr_t;

	// instruction at pc[2]==0 sits in [63:32], pc[2]==1 in [31:0]
	typedef logic [LINE_W-1:0] line_t;

	typedef logic [INST_W-1:0] inst_t;

	// number of instructions offered or accepted in a cycle
	typedef logic [COUNT_W-1:0] count_t;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

	// major opcode field and branch displacement field
	parameter int OPCODE_LSB = 26;
	parameter int OPCODE_MSB = 31;
	parameter int DISP_LSB = 0;
	parameter int DISP_MSB = 20;	// 21 bit signed, in instructions

	typedef enum logic [5:0] {
		OP_CALL_PAL = 6'h00,
		OP_LDA = 6'h08, OP_LDAH = 6'h09, OP_LDBU = 6'h0a, OP_LDQ_U = 6'h0b,
		OP_LDWU = 6'h0c, OP_STW = 6'h0d, OP_STB = 6'h0e, OP_STQ_U = 6'h0f,
		OP_INTA = 6'h10, OP_INTL = 6'h11, OP_INTS = 6'h12, OP_INTM = 6'h13,
		OP_ITFP = 6'h14, OP_FLTV = 6'h15, OP_FLTI = 6'h16, OP_FLTL = 6'h17,
		OP_JMP = 6'h1a,	// jmp/jsr/ret group, indirect
		OP_LDF = 6'h20, OP_LDL = 6'h28, OP_LDQ = 6'h29,
		OP_STL = 6'h2c, OP_STQ = 6'h2d, OP_STQ_C = 6'h2f,
		OP_BR = 6'h30, OP_FBEQ = 6'h31, OP_FBLT = 6'h32, OP_FBLE = 6'h33,
		OP_BSR = 6'h34, OP_FBNE = 6'h35, OP_FBGE = 6'h36, OP_FBGT = 6'h37,
		OP_BLBC = 6'h38, OP_BEQ = 6'h39, OP_BLT = 6'h3a, OP_BLE = 6'h3b,
		OP_BLBS = 6'h3c, OP_BNE = 6'h3d, OP_BGE = 6'h3e, OP_BGT = 6'h3f
	} opcode_e;

	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_MEM,
		CLASS_COND_BRANCH,
		CLASS_DIRECT_BRANCH,	// br, bsr
		CLASS_JUMP,
		CLASS_OTHER
	} inst_class_e;

	// class of one instruction by its major opcode
	function automatic inst_class_e classify(input logic [31:0] inst);
		opcode_e op;
		inst_class_e cls;
		op = opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
		case (op) inside
			OP_BR, OP_BSR:				cls = CLASS_DIRECT_BRANCH;	// first match wins over range
			[OP_FBEQ:OP_BGT]:			cls = CLASS_COND_BRANCH;
			[OP_INTA:OP_FLTL]:			cls = CLASS_ALU;
			[OP_LDA:OP_STQ_U], [OP_LDF:OP_STQ_C]:	cls = CLASS_MEM;
			OP_JMP:					cls = CLASS_JUMP;
			default:				cls = CLASS_OTHER;	// call_pal, misc, unused
		endcase
		return cls;
	endfunction

endpackage

// File: design/instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
	parameter int IMEM_LINES = 256
) (
	input  logic clock,
	input  logic reset,
	input  logic load_en,
	input  logic [$clog2(IMEM_LINES)-1:0] load_index,
	input  fetch_pkg::line_t load_line,
	input  fetch_pkg::addr_t imem_addr,
	output fetch_pkg::line_t imem_line,
	output logic imem_valid
);

	localparam int IDX_W = $clog2(IMEM_LINES);

	fetch_pkg::line_t mem [IMEM_LINES];	// program image, no reset
	logic ready;				// set once out of reset
	logic [IDX_W-1:0] rd_index;

	// load port, one line per cycle
	always_ff @(posedge clock)
	begin
		if (load_en)
			mem[load_index] <= load_line;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			ready <= 1'b0;
		else
			ready <= 1'b1;
	end

	assign rd_index = imem_addr[fetch_pkg::LINE_OFFSET +: IDX_W];	// line index
	assign imem_line = mem[rd_index];
	assign imem_valid = ready & ~load_en;	// not while loading

	// fetch must stay inside the loaded image
	a_addr_in_range: assert property (@(posedge clock) disable iff (reset)
		imem_valid |-> (imem_addr[63:fetch_pkg::LINE_OFFSET] < IMEM_LINES))
		else $error("instr_mem: fetch address %h beyond depth", imem_addr);

endmodule

// File: design/branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer #(
	parameter int BTB_ENTRIES = 16
) (
	input  logic clock,
	input  logic reset,
	input  fetch_pkg::addr_t lookup_pc0,
	input  fetch_pkg::addr_t lookup_pc1,
	output logic hit0,
	output logic hit1,
	output fetch_pkg::addr_t target0,
	output fetch_pkg::addr_t target1,
	input  logic train_en,
	input  fetch_pkg::addr_t train_pc,
	input  fetch_pkg::addr_t train_target
);

	localparam int IDX_W = $clog2(BTB_ENTRIES);
	localparam int TAG_W = fetch_pkg::ADDR_W - 2 - IDX_W;	// pc bits above the index

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	logic [TAG_W-1:0] tags [BTB_ENTRIES];
	fetch_pkg::addr_t targets [BTB_ENTRIES];
	logic [BTB_ENTRIES-1:0] valid;		// only state that reset clears

	logic [IDX_W-1:0] idx0, idx1, widx;
	logic [TAG_W-1:0] tag0, tag1, wtag;

	// index from word address, tag from the rest
	assign idx0 = lookup_pc0[2 +: IDX_W];
	assign idx1 = lookup_pc1[2 +: IDX_W];
	assign widx = train_pc[2 +: IDX_W];
	assign tag0 = lookup_pc0[fetch_pkg::ADDR_W-1 -: TAG_W];
	assign tag1 = lookup_pc1[fetch_pkg::ADDR_W-1 -: TAG_W];
	assign wtag = train_pc[fetch_pkg::ADDR_W-1 -: TAG_W];

	//////////////////////////////////////////////////
	// write port, training from decode
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			valid <= '0;
		else if (train_en)
			valid[widx] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (train_en)
		begin
			tags[widx] <= wtag;	// overwrite, no replacement policy
			targets[widx] <= train_target;
		end
	end

	//////////////////////////////////////////////////
	// two read ports, combinational
	//////////////////////////////////////////////////

	assign hit0 = valid[idx0] && (tags[idx0] == tag0);
	assign hit1 = valid[idx1] && (tags[idx1] == tag1);
	assign target0 = targets[idx0];
	assign target1 = targets[idx1];

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
	input  logic clock,
	input  logic reset,
	output fetch_pkg::addr_t imem_addr,
	input  fetch_pkg::line_t imem_line,
	input  logic imem_valid,
	input  logic btb_hit0,
	input  logic btb_hit1,
	input  fetch_pkg::addr_t btb_target0,
	input  fetch_pkg::addr_t btb_target1,
	output logic slot_valid0,
	output logic slot_valid1,
	output fetch_pkg::inst_t slot_inst0,
	output fetch_pkg::inst_t slot_inst1,
	output fetch_pkg::addr_t slot_pc0,
	output fetch_pkg::addr_t slot_pc1,
	output logic slot_pred_taken0,
	output logic slot_pred_taken1,
	output fetch_pkg::addr_t slot_pred_target0,
	output fetch_pkg::addr_t slot_pred_target1,
	input  fetch_pkg::count_t take_count,
	input  logic redirect,
	input  fetch_pkg::addr_t redirect_target
);

	fetch_pkg::addr_t pc;		// pc of slot 0
	fetch_pkg::addr_t next_pc;

	// line aligned fetch
	assign imem_addr = {pc[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_OFFSET],
		{fetch_pkg::LINE_OFFSET{1'b0}}};

	//////////////////////////////////////////////////
	// slot extraction
	//////////////////////////////////////////////////

	assign slot_pc0 = pc;
	assign slot_pc1 = pc + 64'd4;	// only used when pc is line aligned
	assign slot_inst0 = pc[2] ? imem_line[31:0] : imem_line[63:32];
	assign slot_inst1 = imem_line[31:0];	// lower half, second in order

	assign slot_valid0 = imem_valid;
	assign slot_pred_taken0 = slot_valid0 & btb_hit0;
	assign slot_pred_target0 = btb_target0;

	// nothing past a predicted taken slot 0, nothing past line end
	assign slot_valid1 = imem_valid & ~pc[2] & ~slot_pred_taken0;
	assign slot_pred_taken1 = slot_valid1 & btb_hit1;
	assign slot_pred_target1 = btb_target1;

	//////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////

	always_comb
	begin
		if (redirect)
			next_pc = redirect_target;	// decode fixes a missed branch
		else
		begin
			case (take_count)
				2'd1:	next_pc = slot_pred_taken0 ? slot_pred_target0 : pc + 64'd4;
				2'd2:	next_pc = slot_pred_taken1 ? slot_pred_target1 : pc + 64'd8;
				default:	next_pc = pc;	// stall, hold
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0;	// boot at address 0
		else
			pc <= next_pc;
	end

	// decode may only take what was offered
	a_take_le_offer: assert property (@(posedge clock) disable iff (reset)
		take_count <= (fetch_pkg::count_t'(slot_valid0) + fetch_pkg::count_t'(slot_valid1)))
		else $error("fetch_stage: take_count %0d over offered slots", take_count);

	a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("fetch_stage: misaligned pc %h", pc);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic slot_valid0,
	input  logic slot_valid1,
	input  fetch_pkg::inst_t slot_inst0,
	input  fetch_pkg::inst_t slot_inst1,
	input  fetch_pkg::addr_t slot_pc0,
	input  fetch_pkg::addr_t slot_pc1,
	input  logic slot_pred_taken0,
	input  logic slot_pred_taken1,
	input  fetch_pkg::addr_t slot_pred_target0,
	input  fetch_pkg::addr_t slot_pred_target1,
	input  fetch_pkg::count_t issue_free,
	output fetch_pkg::count_t take_count,
	output logic redirect,
	output fetch_pkg::addr_t redirect_target,
	output logic train_en,
	output fetch_pkg::addr_t train_pc,
	output fetch_pkg::addr_t train_target,
	output logic out_valid0,
	output logic out_valid1,
	output fetch_pkg::inst_t out_inst0,
	output fetch_pkg::inst_t out_inst1,
	output fetch_pkg::addr_t out_pc0,
	output fetch_pkg::addr_t out_pc1,
	output fetch_pkg::addr_t out_npc0,
	output fetch_pkg::addr_t out_npc1,
	output isa_pkg::inst_class_e out_class0,
	output isa_pkg::inst_class_e out_class1
);

	isa_pkg::inst_class_e class0, class1;
	logic direct0, direct1;			// br or bsr
	logic take0, take1;			// accepted this cycle
	logic miss0, miss1;			// prediction disagrees with decode
	fetch_pkg::addr_t br_target0, br_target1;

	//////////////////////////////////////////////////
	// classify and resolve direct branches
	//////////////////////////////////////////////////

	assign class0 = isa_pkg::classify(slot_inst0);
	assign class1 = isa_pkg::classify(slot_inst1);
	assign direct0 = (class0 == isa_pkg::CLASS_DIRECT_BRANCH);
	assign direct1 = (class1 == isa_pkg::CLASS_DIRECT_BRANCH);

	// target = pc + 4 + 4 * sext(disp)
	assign br_target0 = slot_pc0 + 64'd4 +
		{{41{slot_inst0[isa_pkg::DISP_MSB]}}, slot_inst0[isa_pkg::DISP_MSB:isa_pkg::DISP_LSB], 2'b00};
	assign br_target1 = slot_pc1 + 64'd4 +
		{{41{slot_inst1[isa_pkg::DISP_MSB]}}, slot_inst1[isa_pkg::DISP_MSB:isa_pkg::DISP_LSB], 2'b00};

	assign miss0 = ~slot_pred_taken0 | (slot_pred_target0 != br_target0);
	assign miss1 = ~slot_pred_taken1 | (slot_pred_target1 != br_target1);

	//////////////////////////////////////////////////
	// acceptance, in order, bounded by issue_free
	//////////////////////////////////////////////////

	assign take0 = slot_valid0 & (issue_free != 2'd0);
	assign take1 = take0 & slot_valid1 & (issue_free >= 2'd2) & ~direct0;	// stop after br
	assign take_count = fetch_pkg::count_t'(take0) + fetch_pkg::count_t'(take1);

	// at most one direct branch is accepted per cycle
	always_comb
	begin
		if (take1 & direct1)
		begin
			redirect = miss1;
			redirect_target = br_target1;
			train_pc = slot_pc1;
		end
		else
		begin
			redirect = take0 & direct0 & miss0;
			redirect_target = br_target0;
			train_pc = slot_pc0;
		end
	end

	assign train_en = redirect;		// learn every missed direct branch
	assign train_target = redirect_target;

	//////////////////////////////////////////////////
	// output registers toward dispatch
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			out_valid0 <= 1'b0;
			out_valid1 <= 1'b0;
		end
		else
		begin
			out_valid0 <= take0;
			out_valid1 <= take1;	// never without slot 0
		end
	end

	// payload, meaningful only with the valid bits
	always_ff @(posedge clock)
	begin
		out_inst0 <= slot_inst0;
		out_inst1 <= slot_inst1;
		out_pc0 <= slot_pc0;
		out_pc1 <= slot_pc1;
		out_npc0 <= slot_pc0 + 64'd4;
		out_npc1 <= slot_pc1 + 64'd4;
		out_class0 <= class0;
		out_class1 <= class1;
	end

	// fetch restarts at the branch target one edge after a redirect
	a_redirect_restart: assert property (@(posedge clock) disable iff (reset)
		redirect |=> (slot_pc0 == $past(redirect_target)))
		else $error("decode_stage: redirect not followed by fetch at target");

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
	parameter int BTB_ENTRIES = 16,
	parameter int IMEM_LINES = 256
) (
	input  logic clock,
	input  logic reset,
	input  logic load_en,
	input  logic [$clog2(IMEM_LINES)-1:0] load_index,
	input  fetch_pkg::line_t load_line,
	input  fetch_pkg::count_t issue_free,
	output logic out_valid0,
	output logic out_valid1,
	output fetch_pkg::inst_t out_inst0,
	output fetch_pkg::inst_t out_inst1,
	output fetch_pkg::addr_t out_pc0,
	output fetch_pkg::addr_t out_pc1,
	output fetch_pkg::addr_t out_npc0,
	output fetch_pkg::addr_t out_npc1,
	output isa_pkg::inst_class_e out_class0,
	output isa_pkg::inst_class_e out_class1
);

	fetch_pkg::addr_t imem_addr;
	fetch_pkg::line_t imem_line;
	logic imem_valid;
	logic btb_hit0, btb_hit1;
	fetch_pkg::addr_t btb_target0, btb_target1;
	logic slot_valid0, slot_valid1;
	fetch_pkg::inst_t slot_inst0, slot_inst1;
	fetch_pkg::addr_t slot_pc0, slot_pc1;
	logic slot_pred_taken0, slot_pred_taken1;
	fetch_pkg::addr_t slot_pred_target0, slot_pred_target1;
	fetch_pkg::count_t take_count;
	logic redirect, train_en;
	fetch_pkg::addr_t redirect_target, train_pc, train_target;

	instr_mem #(.IMEM_LINES(IMEM_LINES)) u_imem (
		.clock(clock), .reset(reset),
		.load_en(load_en), .load_index(load_index), .load_line(load_line),
		.imem_addr(imem_addr), .imem_line(imem_line), .imem_valid(imem_valid)
	);

	fetch_stage u_fetch (
		.clock(clock), .reset(reset),
		.imem_addr(imem_addr), .imem_line(imem_line), .imem_valid(imem_valid),
		.btb_hit0(btb_hit0), .btb_hit1(btb_hit1),
		.btb_target0(btb_target0), .btb_target1(btb_target1),
		.slot_valid0(slot_valid0), .slot_valid1(slot_valid1),
		.slot_inst0(slot_inst0), .slot_inst1(slot_inst1),
		.slot_pc0(slot_pc0), .slot_pc1(slot_pc1),
		.slot_pred_taken0(slot_pred_taken0), .slot_pred_taken1(slot_pred_taken1),
		.slot_pred_target0(slot_pred_target0), .slot_pred_target1(slot_pred_target1),
		.take_count(take_count), .redirect(redirect), .redirect_target(redirect_target)
	);

	// looked up with the slot pcs, trained from decode
	branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
		.clock(clock), .reset(reset),
		.lookup_pc0(slot_pc0), .lookup_pc1(slot_pc1),
		.hit0(btb_hit0), .hit1(btb_hit1),
		.target0(btb_target0), .target1(btb_target1),
		.train_en(train_en), .train_pc(train_pc), .train_target(train_target)
	);

	decode_stage u_decode (
		.clock(clock), .reset(reset),
		.slot_valid0(slot_valid0), .slot_valid1(slot_valid1),
		.slot_inst0(slot_inst0), .slot_inst1(slot_inst1),
		.slot_pc0(slot_pc0), .slot_pc1(slot_pc1),
		.slot_pred_taken0(slot_pred_taken0), .slot_pred_taken1(slot_pred_taken1),
		.slot_pred_target0(slot_pred_target0), .slot_pred_target1(slot_pred_target1),
		.issue_free(issue_free), .take_count(take_count),
		.redirect(redirect), .redirect_target(redirect_target),
		.train_en(train_en), .train_pc(train_pc), .train_target(train_target),
		.out_valid0(out_valid0), .out_valid1(out_valid1),
		.out_inst0(out_inst0), .out_inst1(out_inst1),
		.out_pc0(out_pc0), .out_pc1(out_pc1),
		.out_npc0(out_npc0), .out_npc1(out_npc1),
		.out_class0(out_class0), .out_class1(out_class1)
	);

endmodule

// File: test/fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker #(
	parameter int IMAGE_WORDS = 512,	// two words per memory line
	parameter int LOOP_START = 96,		// word index of the loop head
	parameter int LOOP_ITERS = 6
) (
	input  logic clock,
	input  logic reset,
	input  logic load_en,
	input  fetch_pkg::count_t issue_free,
	input  logic out_valid0,
	input  logic out_valid1,
	input  fetch_pkg::inst_t out_inst0,
	input  fetch_pkg::inst_t out_inst1,
	input  fetch_pkg::addr_t out_pc0,
	input  fetch_pkg::addr_t out_pc1,
	input  fetch_pkg::addr_t out_npc0,
	input  fetch_pkg::addr_t out_npc1,
	input  isa_pkg::inst_class_e out_class0,
	input  isa_pkg::inst_class_e out_class1,
	output logic done,
	output int errors,
	output int checked
);

	localparam int WORD_W = $clog2(IMAGE_WORDS);

	logic [31:0] image [IMAGE_WORDS];	// program image, written by the testbench
	fetch_pkg::addr_t expect_pc [$];	// pcs still to come, in program order
	fetch_pkg::count_t free_at_edge;	// issue_free seen at the last edge
	logic quiet_at_edge;			// reset or loading at the last edge

	task automatic store_word(input int idx, input logic [31:0] word);
		image[idx] = word;
	endtask

	function automatic logic [31:0] word_at(input fetch_pkg::addr_t pc);
		return image[pc[2 +: WORD_W]];
	endfunction

	//////////////////////////////////////////////////
	// reference model of the instruction stream
	//////////////////////////////////////////////////

	// class by major opcode, straight from the isa opcode map
	function automatic isa_pkg::inst_class_e ref_class(input logic [31:0] inst);
		logic [5:0] op;
		isa_pkg::inst_class_e cls;
		op = inst[31:26];
		if (op == 6'h30 || op == 6'h34)
			cls = isa_pkg::CLASS_DIRECT_BRANCH;	// br, bsr
		else if (op >= 6'h30)
			cls = isa_pkg::CLASS_COND_BRANCH;
		else if (op >= 6'h10 && op <= 6'h17)
			cls = isa_pkg::CLASS_ALU;
		else if ((op >= 6'h08 && op <= 6'h0f) || (op >= 6'h20 && op <= 6'h2f))
			cls = isa_pkg::CLASS_MEM;
		else if (op == 6'h1a)
			cls = isa_pkg::CLASS_JUMP;
		else
			cls = isa_pkg::CLASS_OTHER;
		return cls;
	endfunction

	// direct branches go to pc + 4 + 4 * disp, everything else falls through
	function automatic fetch_pkg::addr_t ref_next_pc(input fetch_pkg::addr_t pc);
		logic [31:0] inst;
		fetch_pkg::addr_t disp;
		inst = word_at(pc);
		disp = {{43{inst[20]}}, inst[20:0]};	// sign extend 21 bits
		if (ref_class(inst) == isa_pkg::CLASS_DIRECT_BRANCH)
			return pc + 64'd4 + (disp << 2);
		return pc + 64'd4;
	endfunction

	// walk from pc 0 through the prefix and the counted loop iterations
	task automatic build_expected();
		fetch_pkg::addr_t pc;
		fetch_pkg::addr_t loop_pc;
		int visits;
		pc = '0;
		loop_pc = fetch_pkg::addr_t'(LOOP_START) << 2;
		visits = 0;
		expect_pc.delete();
		while (visits <= LOOP_ITERS)
		begin
			expect_pc.push_back(pc);
			pc = ref_next_pc(pc);
			if (pc == loop_pc)
				visits++;	// one more pass of the loop
		end
	endtask

	//////////////////////////////////////////////////
	// comparing process
	//////////////////////////////////////////////////

	task automatic check_slot(input int slot, input fetch_pkg::addr_t pc,
		input fetch_pkg::inst_t inst, input fetch_pkg::addr_t npc,
		input isa_pkg::inst_class_e cls);
		fetch_pkg::addr_t exp_pc;
		logic [31:0] exp_inst;
		isa_pkg::inst_class_e exp_class;
		if (expect_pc.size() == 0)
		begin
			$display("%0t: slot %0d valid with no instruction left to expect", $time, slot);
			errors++;
			return;
		end
		exp_pc = expect_pc.pop_front();
		exp_inst = word_at(exp_pc);
		exp_class = ref_class(exp_inst);
		if (pc !== exp_pc)
		begin
			$display("[ERROR] %0t out_pc%0d expected %h got %h", $time, slot, exp_pc, pc);
			errors++;
		end
		if (inst !== exp_inst)
		begin
			$display("[ERROR] %0t out_inst%0d expected %h got %h", $time, slot, exp_inst, inst);
			errors++;
		end
		if (npc !== exp_pc + 64'd4)
		begin
			$display("[ERROR] %0t out_npc%0d expected %h got %h", $time, slot,
				exp_pc + 64'd4, npc);
			errors++;
		end
		if (cls !== exp_class)
		begin
			$display("[ERROR] %0t out_class%0d expected %s got %s", $time, slot,
				exp_class.name(), cls.name());
			errors++;
		end
		checked++;
		if (expect_pc.size() == 0)
			done = 1'b1;	// whole stream seen
	endtask

	initial
	begin
		done = 1'b0;
		errors = 0;
		checked = 0;
		@(negedge reset);
		build_expected();	// image is in place by now
	end

	// what the outputs after this edge were accepted under
	always @(posedge clock)
	begin
		free_at_edge <= issue_free;
		quiet_at_edge <= reset | load_en;
	end

	// outputs are stable half a cycle after the edge
	always @(negedge clock)
	begin
		int shown;
		shown = int'(out_valid0) + int'(out_valid1);
		if (!done)
		begin
			if (quiet_at_edge && shown != 0)
			begin
				$display("%0t: output valid during reset or program load", $time);
				errors++;
			end
			if (out_valid1 && !out_valid0)
			begin
				$display("%0t: slot 1 valid without slot 0", $time);
				errors++;
			end
			if (shown > int'(free_at_edge))
			begin
				$display("[ERROR] %0t out_valid count expected at most %0d got %0d",
					$time, free_at_edge, shown);
				errors++;
			end
			if (out_valid0)
				check_slot(0, out_pc0, out_inst0, out_npc0, out_class0);
			if (out_valid1 && !done)
				check_slot(1, out_pc1, out_inst1, out_npc1, out_class1);
		end
	end

endmodule

// File: test/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;

	localparam int IMEM_LINES = 256;
	localparam int BTB_ENTRIES = 16;
	localparam int IMAGE_WORDS = 2 * IMEM_LINES;
	localparam int LIDX_W = $clog2(IMEM_LINES);
	localparam int CLOCK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;		// inputs change just after the edge
	localparam int RESET_CYCLES = 3;
	localparam int PREFIX_WORDS = 96;	// straight code with forward jumps
	localparam int LOOP_WORDS = 14;		// loop body, last word jumps back
	localparam int LOOP_ITERS = 6;
	localparam int MAX_EXPECT = PREFIX_WORDS + LOOP_ITERS * LOOP_WORDS;
	localparam int LIMIT_CYCLES = IMEM_LINES + 20 * MAX_EXPECT + 100;
	localparam logic [31:0] SEED = 32'hb6f;

	logic clock;
	logic reset;
	logic load_en;
	logic [LIDX_W-1:0] load_index;
	fetch_pkg::line_t load_line;
	fetch_pkg::count_t issue_free;
	logic out_valid0, out_valid1;
	fetch_pkg::inst_t out_inst0, out_inst1;
	fetch_pkg::addr_t out_pc0, out_pc1;
	fetch_pkg::addr_t out_npc0, out_npc1;
	isa_pkg::inst_class_e out_class0, out_class1;
	logic done;
	int errors;
	int checked;
	logic [31:0] prog [IMAGE_WORDS];

	fetch_top #(.BTB_ENTRIES(BTB_ENTRIES), .IMEM_LINES(IMEM_LINES)) dut (
		.clock(clock), .reset(reset),
		.load_en(load_en), .load_index(load_index), .load_line(load_line),
		.issue_free(issue_free),
		.out_valid0(out_valid0), .out_valid1(out_valid1),
		.out_inst0(out_inst0), .out_inst1(out_inst1),
		.out_pc0(out_pc0), .out_pc1(out_pc1),
		.out_npc0(out_npc0), .out_npc1(out_npc1),
		.out_class0(out_class0), .out_class1(out_class1)
	);

	fetch_checker #(.IMAGE_WORDS(IMAGE_WORDS), .LOOP_START(PREFIX_WORDS),
		.LOOP_ITERS(LOOP_ITERS)) chk (
		.clock(clock), .reset(reset), .load_en(load_en), .issue_free(issue_free),
		.out_valid0(out_valid0), .out_valid1(out_valid1),
		.out_inst0(out_inst0), .out_inst1(out_inst1),
		.out_pc0(out_pc0), .out_pc1(out_pc1),
		.out_npc0(out_npc0), .out_npc1(out_npc1),
		.out_class0(out_class0), .out_class1(out_class1),
		.done(done), .errors(errors), .checked(checked)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////
	// program generation
	//////////////////////////////////////////////////

	// operate, memory, conditional branch or call_pal, never a direct branch
	function automatic logic [31:0] random_plain_inst();
		logic [31:0] rnd;
		logic [5:0] op;
		rnd = $urandom;
		case (rnd[31:29])
			3'd0, 3'd1, 3'd2:	op = {3'b010, rnd[28:26]};	// 0x10-0x17
			3'd3:			op = {3'b001, rnd[28:26]};	// 0x08-0x0f
			3'd4, 3'd5:		op = {3'b101, rnd[28:26]};	// 0x28-0x2f
			3'd6:			op = {3'b111, rnd[28:26]};	// falls through in fetch
			default:		op = 6'h00;
		endcase
		return {op, rnd[25:0]};
	endfunction

	function automatic logic [31:0] encode_branch(input logic bsr, input int disp);
		logic [31:0] d;
		logic [31:0] rnd;
		d = disp;
		rnd = $urandom;	// ra field is don't care
		return {(bsr ? 6'h34 : 6'h30), rnd[4:0], d[20:0]};
	endfunction

	task automatic build_program();
		int w;
		int skip;
		logic [31:0] rnd;
		logic [31:0] fill;
		for (w = 0; w < PREFIX_WORDS; w++)
		begin
			rnd = $urandom;
			if (rnd[3:0] < 4'd3)
			begin
				skip = int'(rnd[5:4]) + 1;	// jump 1 to 4 words ahead
				if (w + 1 + skip > PREFIX_WORDS)
					skip = PREFIX_WORDS - w - 1;	// land at most on the loop head
				prog[w] = encode_branch(rnd[8], skip);
			end
			else
				prog[w] = random_plain_inst();
		end
		for (w = PREFIX_WORDS; w < PREFIX_WORDS + LOOP_WORDS; w++)
			prog[w] = random_plain_inst();
		prog[PREFIX_WORDS + 3] = encode_branch(1'b1, 2);
		prog[PREFIX_WORDS + 8] = encode_branch(1'b0, 1);
		prog[PREFIX_WORDS + LOOP_WORDS - 1] = encode_branch(1'b0, -LOOP_WORDS);	// back to head
		// never reached, filled so every line reads defined
		for (w = PREFIX_WORDS + LOOP_WORDS; w < IMAGE_WORDS; w++)
		begin
			fill = w;
			prog[w] = {6'h11, fill[25:0] ^ 26'h15a_a5a5};
		end
	endtask

	task automatic copy_image();
		int w;
		for (w = 0; w < IMAGE_WORDS; w++)
			chk.store_word(w, prog[w]);
	endtask

	// back end takes 0, 1 or 2
	task automatic draw_issue_free();
		logic [31:0] pick;
		pick = $urandom % 3;
		issue_free = pick[1:0];
	endtask

	// one line per cycle, reset drops part way through
	task automatic load_program();
		logic [31:0] idx;
		for (idx = 0; idx < IMEM_LINES; idx++)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			if (idx == RESET_CYCLES - 1)
				reset = 1'b0;
			load_en = 1'b1;
			load_index = idx[LIDX_W-1:0];
			load_line = {prog[2 * idx], prog[2 * idx + 1]};	// even word in upper half
			draw_issue_free();	// back end may already ask, fetch must hold off
		end
		@(posedge clock);
		#DRIVE_DELAY;
		load_en = 1'b0;
		draw_issue_free();
	endtask

	//////////////////////////////////////////////////
	// stimulus and end of run
	//////////////////////////////////////////////////

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		load_en = 1'b0;
		load_index = '0;
		load_line = '0;
		issue_free = '0;
		void'($urandom(SEED));
		build_program();
		copy_image();
		load_program();
		while (!done)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			draw_issue_free();
		end
		@(posedge clock);
		$display("checked %0d instructions, %0d errors", checked, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// stall guard, sized from the longest possible stream
	initial
	begin
		#(LIMIT_CYCLES * CLOCK_PERIOD);
		$display("timeout: stream stalled after %0d instructions in %0d cycles",
			checked, LIMIT_CYCLES);
		$display("checked %0d instructions, %0d errors", checked, errors);
		$display("Test failed");
		$finish;
	end

endmodule

// File: vlog.f
design/fetch_pkg.sv
design/isa_pkg.sv
design/instr_mem.sv
design/branch_target_buffer.sv
design/fetch_stage.sv
design/decode_stage.sv
design/fetch_top.sv
test/fetch_checker.sv
test/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - design/fetch_pkg.sv
  - design/isa_pkg.sv
  - design/instr_mem.sv
  - design/branch_target_buffer.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/fetch_top.sv
  - target: test
    files:
      - test/fetch_checker.sv
      - test/tb_fetch.sv
